// File: src/fw_pkg.sv
// packet, key, flag, verdict and connection-state types, referenced by scoped name
`default_nettype none

package fw_pkg;

   typedef logic [31:0] ip_addr_t;
   typedef logic [15:0] port_t;
   typedef logic [7:0]  proto_t;

   // five-tuple, source address in the top bits
   typedef struct packed {
      ip_addr_t src_ip;
      ip_addr_t dst_ip;
      proto_t   proto;
      port_t    src_port;
      port_t    dst_port;
   } key_t;

   typedef struct packed {
      logic syn;
      logic ack;
      logic fin;
      logic rst;
   } tcp_flags_t;

   typedef struct packed {
      key_t       key;
      tcp_flags_t flags;
      logic       is_tcp;   // non-TCP traffic bypasses the table
   } pkt_t;

   typedef enum logic [2:0] {
      CLOSED      = 3'd0,
      SYN_SENT    = 3'd1,
      SYN_RCVD    = 3'd2,
      ESTABLISHED = 3'd3,
      FIN_WAIT1   = 3'd4,
      FIN_WAIT2   = 3'd5,
      CLOSING     = 3'd6,
      LAST_ACK    = 3'd7
   } conn_state_e;

   typedef struct packed {
      logic accept;
      logic hit;
   } verdict_t;

   typedef enum logic [1:0] {
      OP_NONE   = 2'd0,
      OP_UPDATE = 2'd1,
      OP_INSERT = 2'd2,
      OP_DELETE = 2'd3
   } table_op_e;

   // key as seen from the other end of the connection
   function automatic key_t reverse_key(key_t k);
      key_t r;
      r.src_ip   = k.dst_ip;
      r.dst_ip   = k.src_ip;
      r.proto    = k.proto;
      r.src_port = k.dst_port;
      r.dst_port = k.src_port;
      return r;
   endfunction

endpackage

`default_nettype wire

// File: src/wb_pkg.sv
// Wishbone request/response structs and the word map of a table entry on the bus
`default_nettype none

package wb_pkg;

   typedef logic [31:0] wb_data_t;
   typedef logic [15:0] wb_adr_t;

   // master side, held until ack
   typedef struct packed {
      logic     cyc;
      logic     stb;
      logic     we;
      wb_adr_t  adr;
      wb_data_t dat;
   } wb_req_t;

   typedef struct packed {
      logic     ack;
      wb_data_t dat;
   } wb_rsp_t;

   ////////////////////////////////////////////////
   // word map inside one entry
   parameter int KEY_WORDS     = 4;   // key slices, low slice first
   parameter int STATE_WORD    = 4;   // bit 8 valid, bits 2:0 state
   parameter int WORD_SEL_BITS = 3;

endpackage

`default_nettype wire

// File: src/conn_table.sv
// exact-match connection table with a pipeline pair write port and a bus word port
`timescale 1ns/1ps
`default_nettype none

module conn_table #(
   parameter int TABLE_DEPTH = 16,
   localparam int IDX_W = $clog2(TABLE_DEPTH)
) (
   input  logic                              clk,
   input  logic                              is_RST_held,
   input  fw_pkg::key_t                      match_key,
   output logic                              hit,
   output logic [IDX_W-1:0]                  hit_index,
   output fw_pkg::conn_state_e               hit_state,
   input  fw_pkg::table_op_e                 op,
   input  logic [IDX_W-1:0]                  op_index,
   input  fw_pkg::key_t                      op_key,
   input  fw_pkg::conn_state_e               op_state,
   input  logic [IDX_W-1:0]                  word_index,
   input  logic [wb_pkg::WORD_SEL_BITS-1:0]  word_sel,
   input  logic                              word_we,
   input  wb_pkg::wb_data_t                  word_wdata,
   output wb_pkg::wb_data_t                  word_rdata,
   output logic                              word_grant
);

   localparam int KEY_BITS = $bits(fw_pkg::key_t);
   localparam int EXT_BITS = 32 * wb_pkg::KEY_WORDS;
   localparam logic [IDX_W-1:0] PAIR_MASK = ~IDX_W'(1);

   logic [TABLE_DEPTH-1:0]  valid_q;
   fw_pkg::key_t            key_q [TABLE_DEPTH];
   fw_pkg::conn_state_e     state_q [TABLE_DEPTH];

   logic [TABLE_DEPTH-1:0]  match_vec;
   logic [IDX_W-1:0]        even_idx;
   logic [IDX_W-1:0]        odd_idx;
   logic [EXT_BITS-1:0]     key_ext;   // addressed key, padded to whole words
   logic [EXT_BITS-1:0]     key_wr;
   logic                    key_word;
   logic                    state_word;

   ///////////////////////////////////////////////////
   // compare and priority encode, lowest index wins
   always_comb begin
      hit_index = '0;
      for (int i = 0; i < TABLE_DEPTH; i++) begin
         match_vec[i] = valid_q[i] && (key_q[i] == match_key);
      end
      for (int i = TABLE_DEPTH - 1; i >= 0; i--) begin
         if (match_vec[i]) begin
            hit_index = IDX_W'(i);
         end
      end
   end

   assign hit       = |match_vec;
   assign hit_state = state_q[hit_index];

   ///////////////////////////////////////////////////
   // word port decode
   assign even_idx   = op_index & PAIR_MASK;
   assign odd_idx    = even_idx | IDX_W'(1);
   assign key_word   = word_sel < wb_pkg::KEY_WORDS;
   assign state_word = word_sel == wb_pkg::STATE_WORD;
   assign word_grant = word_we && (op == fw_pkg::OP_NONE);   // pipeline has priority

   always_comb begin
      key_ext = {{(EXT_BITS - KEY_BITS){1'b0}}, key_q[word_index]};
      key_wr  = key_ext;
      key_wr[word_sel[1:0] * 32 +: 32] = word_wdata;
      word_rdata = '0;
      if (key_word) begin
         word_rdata = key_ext[word_sel[1:0] * 32 +: 32];
      end else if (state_word) begin
         word_rdata[8]   = valid_q[word_index];
         word_rdata[2:0] = state_q[word_index];
      end
      // words 5..7 stay zero
   end

   ///////////////////////////////////////////////////
   // valid bits
   always_ff @(posedge clk) begin
      if (is_RST_held) begin
         valid_q <= '0;
      end else begin
         case (op)
            fw_pkg::OP_INSERT: begin
               valid_q[even_idx] <= 1'b1;
               valid_q[odd_idx]  <= 1'b1;
            end
            fw_pkg::OP_DELETE: begin
               valid_q[even_idx] <= 1'b0;
               valid_q[odd_idx]  <= 1'b0;
            end
            fw_pkg::OP_NONE: begin
               if (word_we && state_word) valid_q[word_index] <= word_wdata[8];
            end
            default: ;
         endcase
      end
   end

   // keys and states
   always_ff @(posedge clk) begin
      case (op)
         fw_pkg::OP_INSERT: begin
            key_q[even_idx]   <= op_key;
            key_q[odd_idx]    <= fw_pkg::reverse_key(op_key);
            state_q[even_idx] <= fw_pkg::SYN_SENT;
            state_q[odd_idx]  <= fw_pkg::SYN_SENT;
         end
         fw_pkg::OP_UPDATE: begin
            state_q[even_idx] <= op_state;
            state_q[odd_idx]  <= op_state;
         end
         fw_pkg::OP_NONE: begin
            if (word_we && key_word) begin
               key_q[word_index] <= fw_pkg::key_t'(key_wr[KEY_BITS-1:0]);
            end else if (word_we && state_word) begin
               state_q[word_index] <= fw_pkg::conn_state_e'(word_wdata[2:0]);
            end
         end
         default: ;   // delete only drops the valid bits
      endcase
   end

endmodule

`default_nettype wire

// File: src/tcp_state_update.sv
// combinational TCP flag rules, one packet against one stored connection state
`timescale 1ns/1ps
`default_nettype none

module tcp_state_update (
   input  logic                 found,
   input  fw_pkg::conn_state_e  state,
   input  fw_pkg::tcp_flags_t   flags,
   input  logic                 is_tcp,
   output fw_pkg::conn_state_e  next_state,
   output fw_pkg::verdict_t     verdict,
   output fw_pkg::table_op_e    op
);

   logic pure_syn;
   logic pure_ack;
   logic accept;
   logic close_pair;   // final ack of the teardown

   assign pure_syn = flags.syn & ~flags.ack & ~flags.fin & ~flags.rst;
   assign pure_ack = flags.ack & ~flags.syn & ~flags.fin & ~flags.rst;

   always_comb begin
      next_state = state;
      accept     = 1'b0;
      close_pair = 1'b0;
      if (found) begin
         if (flags.rst) begin
            next_state = fw_pkg::CLOSED;
            accept     = 1'b1;
         end else begin
            case (state)
               fw_pkg::CLOSED: if (pure_syn) begin
                  next_state = fw_pkg::SYN_SENT;
                  accept     = 1'b1;
               end
               fw_pkg::SYN_SENT: if (flags.syn && flags.ack && !flags.fin) begin
                  next_state = fw_pkg::SYN_RCVD;
                  accept     = 1'b1;
               end
               fw_pkg::SYN_RCVD: if (pure_ack) begin
                  next_state = fw_pkg::ESTABLISHED;
                  accept     = 1'b1;
               end
               fw_pkg::ESTABLISHED: if (!flags.syn) begin
                  accept = 1'b1;
                  if (flags.fin) next_state = fw_pkg::FIN_WAIT1;
               end
               fw_pkg::FIN_WAIT1: if (!flags.syn) begin
                  accept = 1'b1;
                  if (flags.fin && flags.ack)  next_state = fw_pkg::LAST_ACK;
                  else if (flags.fin)          next_state = fw_pkg::CLOSING;
                  else if (flags.ack)          next_state = fw_pkg::FIN_WAIT2;
               end
               fw_pkg::FIN_WAIT2: if (!flags.syn) begin
                  accept = 1'b1;
                  if (flags.fin) next_state = fw_pkg::LAST_ACK;
               end
               fw_pkg::CLOSING: if (pure_ack) begin
                  next_state = fw_pkg::LAST_ACK;
                  accept     = 1'b1;
               end
               fw_pkg::LAST_ACK: if (pure_ack) begin
                  accept     = 1'b1;
                  close_pair = 1'b1;
               end
               default: ;   // drop, state kept
            endcase
         end
      end else if (!is_tcp) begin
         accept = 1'b1;
      end else if (pure_syn) begin
         accept = 1'b1;   // new connection, the table sets SYN_SENT
      end
   end

   always_comb begin
      if (close_pair)                           op = fw_pkg::OP_DELETE;
      else if (found && next_state != state)    op = fw_pkg::OP_UPDATE;
      else if (!found && is_tcp && pure_syn)    op = fw_pkg::OP_INSERT;
      else                                      op = fw_pkg::OP_NONE;
   end

   assign verdict = '{accept: accept, hit: found};

endmodule

`default_nettype wire

// File: src/lookup_pipeline.sv
// three-stage lookup: sample, compare with write forwarding, then table write and verdict
`timescale 1ns/1ps
`default_nettype none

module lookup_pipeline #(
   parameter int TABLE_DEPTH = 16,
   localparam int IDX_W = $clog2(TABLE_DEPTH)
) (
   input  logic                 clk,
   input  logic                 is_RST_held,
   input  logic                 pkt_valid,
   input  fw_pkg::pkt_t         pkt,
   output fw_pkg::key_t         match_key,
   input  logic                 hit,
   input  logic [IDX_W-1:0]     hit_index,
   input  fw_pkg::conn_state_e  hit_state,
   output fw_pkg::table_op_e    op,
   output logic [IDX_W-1:0]     op_index,
   output fw_pkg::key_t         op_key,
   output fw_pkg::conn_state_e  op_state,
   output logic                 verdict_valid,
   output fw_pkg::verdict_t     verdict
);

   localparam logic [IDX_W-1:0] PAIR_MASK = ~IDX_W'(1);

   logic                 s1_valid;
   fw_pkg::pkt_t         s1_pkt;
   logic                 s2_valid;
   fw_pkg::pkt_t         s2_pkt;
   logic                 s2_hit;
   logic [IDX_W-1:0]     s2_index;
   fw_pkg::conn_state_e  s2_state;

   logic                 fwd_hit;
   logic [IDX_W-1:0]     fwd_index;
   fw_pkg::conn_state_e  fwd_state;
   logic                 same_pair;
   logic                 fwd_key;     // s1 key equals the key being written
   logic                 fwd_rkey;    // ... or its reverse

   fw_pkg::conn_state_e  upd_state;
   fw_pkg::verdict_t     upd_verdict;
   fw_pkg::table_op_e    upd_op;
   logic [IDX_W-1:0]     alloc_ptr;   // next pair to insert, always even

   ///////////////////////////////////////////////////
   // stage 1
   always_ff @(posedge clk) begin
      if (is_RST_held) s1_valid <= 1'b0;
      else             s1_valid <= pkt_valid;
   end

   always_ff @(posedge clk) begin
      if (pkt_valid) s1_pkt <= pkt;
   end

   assign match_key = s1_pkt.key;

   ///////////////////////////////////////////////////
   // stage 2, patch the compare with the write now in flight
   assign same_pair = (hit_index & PAIR_MASK) == (op_index & PAIR_MASK);
   assign fwd_key   = s1_pkt.key == op_key;
   assign fwd_rkey  = s1_pkt.key == fw_pkg::reverse_key(op_key);

   always_comb begin
      fwd_hit   = hit;
      fwd_index = hit_index;
      fwd_state = hit_state;
      case (op)
         fw_pkg::OP_UPDATE: if (hit && same_pair) fwd_state = op_state;
         fw_pkg::OP_INSERT: begin
            if (fwd_key || fwd_rkey) begin
               fwd_hit   = 1'b1;
               fwd_index = fwd_key ? op_index : (op_index | IDX_W'(1));
               fwd_state = fw_pkg::SYN_SENT;
            end else if (hit && same_pair) begin
               fwd_hit = 1'b0;   // oldest pair being overwritten
            end
         end
         fw_pkg::OP_DELETE: if (fwd_key || fwd_rkey) fwd_hit = 1'b0;
         default: ;
      endcase
      if (!s1_pkt.is_tcp) fwd_hit = 1'b0;   // never looked up
   end

   always_ff @(posedge clk) begin
      if (is_RST_held) s2_valid <= 1'b0;
      else             s2_valid <= s1_valid;
   end

   always_ff @(posedge clk) begin
      s2_pkt   <= s1_pkt;
      s2_hit   <= fwd_hit;
      s2_index <= fwd_index;
      s2_state <= fwd_state;
   end

   ///////////////////////////////////////////////////
   // stage 3, write port and verdict
   tcp_state_update tcp_state_update_i (
      .found      (s2_hit),
      .state      (s2_state),
      .flags      (s2_pkt.flags),
      .is_tcp     (s2_pkt.is_tcp),
      .next_state (upd_state),
      .verdict    (upd_verdict),
      .op         (upd_op)
   );

   assign op       = s2_valid ? upd_op : fw_pkg::OP_NONE;
   assign op_index = (upd_op == fw_pkg::OP_INSERT) ? alloc_ptr : s2_index;
   assign op_key   = s2_pkt.key;
   assign op_state = upd_state;

   always_ff @(posedge clk) begin
      if (is_RST_held) begin
         alloc_ptr <= '0;
      end else if (op == fw_pkg::OP_INSERT) begin
         alloc_ptr <= alloc_ptr + IDX_W'(2);   // wraps onto the oldest pair
      end
   end

   always_ff @(posedge clk) begin
      if (is_RST_held) verdict_valid <= 1'b0;
      else             verdict_valid <= s2_valid;
   end

   always_ff @(posedge clk) begin
      verdict <= upd_verdict;
   end

endmodule

`default_nettype wire

// File: src/wb_table_port.sv
// Wishbone classic slave giving word access to table entries
`timescale 1ns/1ps
`default_nettype none

module wb_table_port #(
   parameter int TABLE_DEPTH = 16,
   localparam int IDX_W = $clog2(TABLE_DEPTH)
) (
   input  logic                              clk,
   input  logic                              is_RST_held,
   input  wb_pkg::wb_req_t                   wb_req,
   output wb_pkg::wb_rsp_t                   wb_rsp,
   output logic [IDX_W-1:0]                  word_index,
   output logic [wb_pkg::WORD_SEL_BITS-1:0]  word_sel,
   output logic                              word_we,
   output wb_pkg::wb_data_t                  word_wdata,
   input  wb_pkg::wb_data_t                  word_rdata,
   input  logic                              word_grant
);

   typedef enum logic [1:0] {
      IDLE,
      WAIT_GRANT,
      ACK
   } state_e;

   state_e            state_q;
   wb_pkg::wb_data_t  rdata_q;
   logic              req;

   assign req = wb_req.cyc & wb_req.stb;

   // address split, master holds it until ack
   assign word_sel   = wb_req.adr[wb_pkg::WORD_SEL_BITS-1:0];
   assign word_index = wb_req.adr[wb_pkg::WORD_SEL_BITS +: IDX_W];
   assign word_wdata = wb_req.dat;
   assign word_we    = state_q == WAIT_GRANT;

   ///////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (is_RST_held) begin
         state_q <= IDLE;
      end else begin
         case (state_q)
            IDLE: begin
               if (req) state_q <= wb_req.we ? WAIT_GRANT : ACK;   // reads finish at once
            end
            WAIT_GRANT: begin
               if (word_grant) state_q <= ACK;   // table busy with a pipeline write
            end
            ACK:     state_q <= IDLE;   // single-cycle ack
            default: state_q <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state_q == IDLE && req && !wb_req.we) rdata_q <= word_rdata;
   end

   assign wb_rsp.ack = state_q == ACK;
   assign wb_rsp.dat = rdata_q;

endmodule

`default_nettype wire

// File: src/tcp_conn_tracker.sv
// top of the TCP connection tracker, packet lookup path plus Wishbone table access
`timescale 1ns/1ps
`default_nettype none

module tcp_conn_tracker #(
   parameter int TABLE_DEPTH = 16,   // even, power of two
   localparam int IDX_W = $clog2(TABLE_DEPTH)
) (
   input  logic              clk,
   input  logic              is_RST_held,
   input  logic              pkt_valid,
   input  fw_pkg::pkt_t      pkt,
   output logic              verdict_valid,
   output fw_pkg::verdict_t  verdict,
   input  wb_pkg::wb_req_t   wb_req,
   output wb_pkg::wb_rsp_t   wb_rsp
);

   // lookup and pair write port
   fw_pkg::key_t                      match_key;
   logic                              hit;
   logic [IDX_W-1:0]                  hit_index;
   fw_pkg::conn_state_e               hit_state;
   fw_pkg::table_op_e                 op;
   logic [IDX_W-1:0]                  op_index;
   fw_pkg::key_t                      op_key;
   fw_pkg::conn_state_e               op_state;

   // bus word port
   logic [IDX_W-1:0]                  word_index;
   logic [wb_pkg::WORD_SEL_BITS-1:0]  word_sel;
   logic                              word_we;
   wb_pkg::wb_data_t                  word_wdata;
   wb_pkg::wb_data_t                  word_rdata;
   logic                              word_grant;

   lookup_pipeline #(.TABLE_DEPTH(TABLE_DEPTH)) lookup_pipeline_i (
      .clk           (clk),
      .is_RST_held   (is_RST_held),
      .pkt_valid     (pkt_valid),
      .pkt           (pkt),
      .match_key     (match_key),
      .hit           (hit),
      .hit_index     (hit_index),
      .hit_state     (hit_state),
      .op            (op),
      .op_index      (op_index),
      .op_key        (op_key),
      .op_state      (op_state),
      .verdict_valid (verdict_valid),
      .verdict       (verdict)
   );

   conn_table #(.TABLE_DEPTH(TABLE_DEPTH)) conn_table_i (
      .clk         (clk),
      .is_RST_held (is_RST_held),
      .match_key   (match_key),
      .hit         (hit),
      .hit_index   (hit_index),
      .hit_state   (hit_state),
      .op          (op),
      .op_index    (op_index),
      .op_key      (op_key),
      .op_state    (op_state),
      .word_index  (word_index),
      .word_sel    (word_sel),
      .word_we     (word_we),
      .word_wdata  (word_wdata),
      .word_rdata  (word_rdata),
      .word_grant  (word_grant)
   );

   wb_table_port #(.TABLE_DEPTH(TABLE_DEPTH)) wb_table_port_i (
      .clk         (clk),
      .is_RST_held (is_RST_held),
      .wb_req      (wb_req),
      .wb_rsp      (wb_rsp),
      .word_index  (word_index),
      .word_sel    (word_sel),
      .word_we     (word_we),
      .word_wdata  (word_wdata),
      .word_rdata  (word_rdata),
      .word_grant  (word_grant)
   );

endmodule

`default_nettype wire

// File: verif/tcp_conn_tracker_checker.sv
// verdict latency and Wishbone handshake assertions, bound into the tracker top level
`timescale 1ns/1ps
`default_nettype none

module tcp_conn_tracker_checker (
   input logic              clk,
   input logic              is_RST_held,
   input logic              pkt_valid,
   input logic              verdict_valid,
   input fw_pkg::verdict_t  verdict,
   input wb_pkg::wb_req_t   wb_req,
   input wb_pkg::wb_rsp_t   wb_rsp
);

   //////////////////////////////////////////////////
   // packet side
   // three flops from pkt_valid to verdict_valid, seen one edge late in sampled values
   a_verdict_after_pkt: assert property (@(posedge clk) disable iff (is_RST_held)
      pkt_valid |=> ##2 verdict_valid)
      else $error("verdict_valid missing two edges after a sampled packet");

   a_verdict_has_pkt: assert property (@(posedge clk) disable iff (is_RST_held)
      verdict_valid |-> $past(pkt_valid, 3))
      else $error("verdict_valid without a packet two edges before");

   a_verdict_known: assert property (@(posedge clk) disable iff (is_RST_held)
      verdict_valid |-> !$isunknown(verdict))
      else $error("verdict has unknown bits while valid");

   //////////////////////////////////////////////////
   // bus side
   a_ack_in_cycle: assert property (@(posedge clk) disable iff (is_RST_held)
      $rose(wb_rsp.ack) |-> $past(wb_req.cyc && wb_req.stb))   // raised by a live request
      else $error("ack raised outside a bus cycle");

   a_ack_pulse: assert property (@(posedge clk) disable iff (is_RST_held)
      wb_rsp.ack |=> !wb_rsp.ack)
      else $error("ack held longer than one cycle");

endmodule

bind tcp_conn_tracker tcp_conn_tracker_checker tcp_conn_tracker_checker_i (.*);

`default_nettype wire

// File: verif/tcp_conn_tracker_tb.sv
// testbench for the connection tracker, packet table applied in phases plus Wishbone readback
`timescale 1ns/1ps
`default_nettype none

module tb_tcp_conn_tracker;

   localparam int TABLE_DEPTH = 16;
   localparam int WAIT_LIMIT  = 50;   // cycles per wait loop

   // flags {syn, ack, fin, rst}, verdicts {accept, hit}
   localparam logic [3:0] SYN = 4'b1000;
   localparam logic [3:0] ACK = 4'b0100;
   localparam logic [3:0] FIN = 4'b0010;
   localparam logic [3:0] RST = 4'b0001;
   localparam logic [1:0] V_DROP     = 2'b00;
   localparam logic [1:0] V_NEW      = 2'b10;   // accepted, no entry
   localparam logic [1:0] V_HIT_DROP = 2'b01;
   localparam logic [1:0] V_HIT_ACC  = 2'b11;
   localparam int C_A = 0;
   localparam int C_B = 1;
   localparam int C_C = 2;
   localparam int C_D = 3;   // static pair
   localparam int C_UNK = 4; // never inserted

   typedef struct packed {
      logic [2:0]          phase;
      logic [2:0]          conn;
      logic                rev;   // sent from the far end
      fw_pkg::tcp_flags_t  flags;
      logic                is_tcp;
      fw_pkg::verdict_t    exp_verdict;
   } step_t;

   logic              clk;
   logic              is_RST_held;
   logic              pkt_valid;
   fw_pkg::pkt_t      pkt;
   logic              verdict_valid;
   fw_pkg::verdict_t  verdict;
   wb_pkg::wb_req_t   wb_req;
   wb_pkg::wb_rsp_t   wb_rsp;

   fw_pkg::key_t      keys [5];
   step_t             steps [$];
   fw_pkg::verdict_t  expected_q [$];
   integer            seed;
   wb_pkg::wb_data_t  rd;

   tcp_conn_tracker #(.TABLE_DEPTH(TABLE_DEPTH)) tcp_conn_tracker_i (
      .clk           (clk),
      .is_RST_held   (is_RST_held),
      .pkt_valid     (pkt_valid),
      .pkt           (pkt),
      .verdict_valid (verdict_valid),
      .verdict       (verdict),
      .wb_req        (wb_req),
      .wb_rsp        (wb_rsp)
   );

   initial clk = 1'b0;
   always #4 clk = ~clk;

   //////////////////////////////////////////////////
   // helpers
   function automatic fw_pkg::key_t flip_key(input fw_pkg::key_t k);
      fw_pkg::key_t r;
      r = k;
      r.src_ip   = k.dst_ip;
      r.dst_ip   = k.src_ip;
      r.src_port = k.dst_port;
      r.dst_port = k.src_port;
      return r;
   endfunction

   function automatic wb_pkg::wb_adr_t word_adr(input int entry, input int word);
      return wb_pkg::wb_adr_t'((entry << wb_pkg::WORD_SEL_BITS) | word);
   endfunction

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] want);
      if (got !== want) stop_run($sformatf("ERR %s: got 0x%h, expected 0x%h", name, got, want));
   endtask

   task automatic wb_write(input wb_pkg::wb_adr_t adr, input wb_pkg::wb_data_t dat);
      int n;
      @(negedge clk);
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = 1'b1;
      wb_req.adr = adr;
      wb_req.dat = dat;
      n = 0;
      do begin
         @(negedge clk);
         n++;
         if (n > WAIT_LIMIT) stop_run("Wishbone write was never acknowledged");
      end while (wb_rsp.ack !== 1'b1);
      wb_req = '0;
   endtask

   task automatic wb_read(input wb_pkg::wb_adr_t adr, output wb_pkg::wb_data_t dat);
      int n;
      @(negedge clk);
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = 1'b0;
      wb_req.adr = adr;
      n = 0;
      do begin
         @(negedge clk);
         n++;
         if (n > WAIT_LIMIT) stop_run("Wishbone read was never acknowledged");
      end while (wb_rsp.ack !== 1'b1);
      dat = wb_rsp.dat;
      wb_req = '0;
   endtask

   task automatic expect_invalid(input int entry);
      wb_pkg::wb_data_t d;
      wb_read(word_adr(entry, wb_pkg::STATE_WORD), d);
      check_value($sformatf("entry %0d valid", entry), {31'b0, d[8]}, 32'h0);
   endtask

   // key slices low first, then valid and state
   task automatic expect_entry(input int entry, input fw_pkg::key_t k,
                               input fw_pkg::conn_state_e st);
      logic [127:0] ext;
      wb_pkg::wb_data_t d;
      ext = {24'h0, k};
      for (int w = 0; w < wb_pkg::KEY_WORDS; w++) begin
         wb_read(word_adr(entry, w), d);
         check_value($sformatf("entry %0d word %0d", entry, w), d, ext[w*32 +: 32]);
      end
      wb_read(word_adr(entry, wb_pkg::STATE_WORD), d);
      check_value($sformatf("entry %0d state word", entry), d, 32'h100 | 32'(st));
   endtask

   task automatic write_entry(input int entry, input fw_pkg::key_t k,
                              input fw_pkg::conn_state_e st);
      logic [127:0] ext;
      ext = {24'h0, k};
      for (int w = 0; w < wb_pkg::KEY_WORDS; w++) begin
         wb_write(word_adr(entry, w), ext[w*32 +: 32]);
      end
      wb_write(word_adr(entry, wb_pkg::STATE_WORD), 32'h100 | 32'(st));
   endtask

   //////////////////////////////////////////////////
   // packet table
   task automatic add_step(input int phase, input int conn, input bit rev,
                           input logic [3:0] flags, input bit is_tcp, input logic [1:0] v);
      step_t s;
      s.phase       = 3'(phase);
      s.conn        = 3'(conn);
      s.rev         = rev;
      s.flags       = flags;
      s.is_tcp      = is_tcp;
      s.exp_verdict = v;
      steps.push_back(s);
   endtask

   task automatic load_steps();
      add_step(1, C_UNK, 0, ACK, 0, V_NEW);          // non-TCP passes
      add_step(1, C_UNK, 0, SYN, 0, V_NEW);          // no insert without TCP
      add_step(2, C_A, 0, SYN, 1, V_NEW);            // insert pair 0
      add_step(2, C_A, 0, SYN, 1, V_HIT_DROP);       // SYN_SENT needs syn and ack
      add_step(2, C_UNK, 0, ACK, 1, V_DROP);
      add_step(2, C_UNK, 0, FIN | ACK, 1, V_DROP);
      add_step(2, C_UNK, 0, RST, 1, V_DROP);
      add_step(2, C_A, 0, ACK, 0, V_NEW);            // non-TCP never hits
      add_step(3, C_B, 0, SYN, 1, V_NEW);            // pair 2
      add_step(3, C_B, 1, SYN | ACK, 1, V_HIT_ACC);  // SYN_RCVD
      add_step(3, C_B, 0, FIN, 1, V_HIT_DROP);       // out of order
      add_step(3, C_B, 0, ACK, 1, V_HIT_ACC);        // ESTABLISHED
      add_step(3, C_B, 1, ACK, 1, V_HIT_ACC);
      add_step(3, C_B, 0, FIN | ACK, 1, V_HIT_ACC);  // FIN_WAIT1
      add_step(3, C_B, 1, ACK, 1, V_HIT_ACC);        // FIN_WAIT2
      add_step(3, C_B, 1, FIN | ACK, 1, V_HIT_ACC);  // LAST_ACK
      add_step(3, C_B, 0, ACK, 1, V_HIT_ACC);        // pair deleted
      add_step(3, C_B, 0, ACK, 1, V_DROP);
      add_step(4, C_C, 0, SYN, 1, V_NEW);            // back to back, pair 4
      add_step(4, C_C, 1, SYN | ACK, 1, V_HIT_ACC);
      add_step(4, C_C, 0, ACK, 1, V_HIT_ACC);
      add_step(4, C_C, 0, SYN, 1, V_HIT_DROP);
      add_step(4, C_C, 1, ACK, 1, V_HIT_ACC);
      add_step(4, C_C, 0, FIN, 1, V_HIT_ACC);        // FIN_WAIT1
      add_step(4, C_C, 1, FIN, 1, V_HIT_ACC);        // CLOSING
      add_step(4, C_C, 0, ACK, 1, V_HIT_ACC);        // LAST_ACK
      add_step(4, C_C, 1, ACK, 1, V_HIT_ACC);        // delete
      add_step(4, C_C, 0, ACK, 1, V_DROP);
      add_step(5, C_D, 1, RST, 1, V_HIT_ACC);        // static pair to CLOSED
   endtask

   task automatic send_step(input step_t s);
      @(negedge clk);
      pkt_valid  = 1'b1;
      pkt.key    = s.rev ? flip_key(keys[s.conn]) : keys[s.conn];
      pkt.flags  = s.flags;
      pkt.is_tcp = s.is_tcp;
      expected_q.push_back(s.exp_verdict);
   endtask

   task automatic release_pkt();
      @(negedge clk);
      pkt_valid = 1'b0;
   endtask

   task automatic wait_verdicts();
      int n;
      n = 0;
      while (expected_q.size() != 0) begin
         @(posedge clk);
         n++;
         if (n > WAIT_LIMIT) stop_run("expected verdicts did not arrive in time");
      end
   endtask

   task automatic run_phase(input int phase, input bit burst);
      foreach (steps[i]) begin
         if (steps[i].phase == phase) begin
            send_step(steps[i]);
            if (!burst) begin
               release_pkt();
               wait_verdicts();
            end
         end
      end
      release_pkt();
      wait_verdicts();
   endtask

   // verdicts come back in order, any extra one is an error
   always @(negedge clk) begin : verdict_monitor
      fw_pkg::verdict_t exp_v;
      if (is_RST_held === 1'b0 && verdict_valid === 1'b1) begin
         if (expected_q.size() == 0) begin
            stop_run("a verdict appeared with no packet pending");
         end else begin
            exp_v = expected_q.pop_front();
            check_value("verdict", {30'b0, verdict}, {30'b0, exp_v});
         end
      end
   end

   //////////////////////////////////////////////////
   initial begin
      is_RST_held = 1'b1;
      pkt_valid   = 1'b0;
      pkt         = '0;
      wb_req      = '0;
      seed        = 32'h778f_b45f;
      foreach (keys[i]) begin
         keys[i].src_ip   = $random(seed);
         keys[i].dst_ip   = $random(seed);
         keys[i].proto    = 8'd6;
         keys[i].src_port = $random(seed);
         keys[i].dst_port = $random(seed);
      end
      load_steps();
      repeat (2) @(posedge clk);
      @(negedge clk);
      is_RST_held = 1'b0;

      for (int e = 0; e < TABLE_DEPTH; e++) expect_invalid(e);

      run_phase(1, 0);
      expect_invalid(0);
      expect_invalid(1);
      run_phase(2, 0);
      expect_entry(0, keys[C_A], fw_pkg::SYN_SENT);
      expect_entry(1, flip_key(keys[C_A]), fw_pkg::SYN_SENT);

      // spare words read zero and leave a live entry untouched
      for (int w = 5; w < 8; w++) begin
         wb_write(word_adr(0, w), 32'hdead_beef);
      end
      for (int w = 5; w < 8; w++) begin
         wb_read(word_adr(0, w), rd);
         check_value($sformatf("entry 0 word %0d", w), rd, 32'h0);
      end
      expect_entry(0, keys[C_A], fw_pkg::SYN_SENT);

      run_phase(3, 0);
      expect_invalid(2);
      expect_invalid(3);
      run_phase(4, 1);
      expect_invalid(4);
      expect_invalid(5);

      write_entry(8, keys[C_D], fw_pkg::ESTABLISHED);
      write_entry(9, flip_key(keys[C_D]), fw_pkg::ESTABLISHED);
      run_phase(5, 0);
      expect_entry(8, keys[C_D], fw_pkg::CLOSED);
      expect_entry(9, flip_key(keys[C_D]), fw_pkg::CLOSED);

      if (expected_q.size() != 0) begin
         stop_run("packets left without a verdict");
      end else begin
         $display("*** TEST PASSED ***");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: tcp_conn_tracker.f
src/fw_pkg.sv
src/wb_pkg.sv
src/conn_table.sv
src/tcp_state_update.sv
src/lookup_pipeline.sv
src/wb_table_port.sv
src/tcp_conn_tracker.sv
verif/tcp_conn_tracker_checker.sv
verif/tcp_conn_tracker_tb.sv

// File: Bender.yml
package:
  name: tcp_conn_tracker

sources:
  - files:
      - src/fw_pkg.sv
      - src/wb_pkg.sv
      - src/conn_table.sv
      - src/tcp_state_update.sv
      - src/lookup_pipeline.sv
      - src/wb_table_port.sv
      - src/tcp_conn_tracker.sv
  - target: test
    files:
      - verif/tcp_conn_tracker_checker.sv
      - verif/tcp_conn_tracker_tb.sv
